//--- tb.f
+incdir+include
verilog/arp_pkg.sv
verilog/arp_tx_frame_if.sv
verilog/arp_cache_if.sv
verilog/arp_cache.sv
verilog/arp_rx_filter.sv
verilog/arp_resolver.sv
verilog/arp_tx_arbiter.sv
verilog/arp_top.sv
testbench/tb_arp_top.sv

//--- Makefile
# Verilator flow for the ARP engine testbench

VERILATOR ?= verilator
TOP       ?= tb_arp_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- include/tb_arp_model.svh
`ifndef TB_ARP_MODEL_SVH
`define TB_ARP_MODEL_SVH

// Reference model that lives inside tb_arp_top after its signals

localparam int MODEL_DEPTH = 1 << CACHE_ADDRW;

logic           model_valid [MODEL_DEPTH];
arp_pkg::ip_t   model_ip    [MODEL_DEPTH];
arp_pkg::mac_t  model_mac   [MODEL_DEPTH];

function automatic void model_clear();
    for (int i = 0; i < MODEL_DEPTH; i++) begin
        model_valid[i] = 1'b0;
    end
endfunction

// Direct mapped on the low address bits where a newer sender evicts the older one
function automatic logic model_lookup(input arp_pkg::ip_t ip, output arp_pkg::mac_t mac);
    logic [CACHE_ADDRW-1:0] idx;
    idx = ip[CACHE_ADDRW-1:0];
    mac = model_mac[idx];
    return model_valid[idx] && (model_ip[idx] == ip);
endfunction

// Valid frames teach the sender and requests for our address get a reply
function automatic void model_rx(input logic [15:0] eth_type, input logic [15:0] htype,
                                 input logic [15:0] ptype, input arp_pkg::oper_t oper,
                                 input arp_pkg::mac_t src_mac, input arp_pkg::mac_t sha,
                                 input arp_pkg::ip_t spa, input arp_pkg::ip_t tpa);
    logic [CACHE_ADDRW-1:0] idx;
    idx = spa[CACHE_ADDRW-1:0];
    if (eth_type == arp_pkg::ETH_TYPE_ARP && htype == arp_pkg::HTYPE_ETHERNET &&
            ptype == arp_pkg::PTYPE_IPV4) begin
        model_valid[idx] = 1'b1;
        model_ip[idx]    = spa;
        model_mac[idx]   = sha;
        if (oper == arp_pkg::OPER_REQUEST && tpa == local_ip) begin
            exp_q.push_back({src_mac, arp_pkg::OPER_REPLY, sha, spa});
        end
    end
endfunction

function automatic logic [143:0] model_request_frame(input arp_pkg::ip_t target);
    return {arp_pkg::MAC_BROADCAST, arp_pkg::OPER_REQUEST, arp_pkg::MAC_ZERO, target};
endfunction

// Returns 1 when the expected answer to a client request needs request frames
function automatic logic model_resolve(input arp_pkg::ip_t ip, output arp_pkg::ip_t target,
                                       output logic err, output arp_pkg::mac_t mac);
    logic on_subnet;
    logic hit;
    on_subnet = (ip & subnet_mask) == (local_ip & subnet_mask);
    target    = on_subnet ? ip : gateway_ip;
    err       = 1'b0;
    mac       = arp_pkg::MAC_BROADCAST;
    if (ip == arp_pkg::IP_BROADCAST || (on_subnet && (ip & ~subnet_mask) == ~subnet_mask)) begin
        return 1'b0;
    end
    hit = model_lookup(target, mac);
    if (!hit) begin
        err = 1'b1;
        mac = arp_pkg::MAC_ZERO;
    end
    return !hit;
endfunction

`endif

//--- testbench/tb_arp_top.sv
`timescale 1ns/10ps

module tb_arp_top;

    localparam int          CACHE_ADDRW = 3;
    localparam int          REQ_RET_CNT = 3;
    localparam int          REQ_RET_INT = 40;
    localparam int          REQ_TIMEOUT = 80;
    localparam int          CLK_PERIOD  = 4;
    localparam int          DRIVE_DLY   = 1;
    localparam logic [31:0] SEED        = 32'h527e;
    // Fixed part of the tests plus a full retry sequence for every miss case
    localparam int TEST_CYCLES     = 2000;
    localparam int MISS_CASES      = 4;
    localparam int RETRY_CYCLES    = (REQ_RET_CNT - 1) * (REQ_RET_INT + 1) + REQ_TIMEOUT + 17;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + MISS_CASES * RETRY_CYCLES;

    logic           clk;
    logic           reset;
    arp_pkg::mac_t  local_mac;
    arp_pkg::ip_t   local_ip;
    arp_pkg::ip_t   gateway_ip;
    arp_pkg::ip_t   subnet_mask;
    logic           clear_cache;
    logic           rx_valid;
    logic [15:0]    rx_eth_type;
    arp_pkg::mac_t  rx_src_mac;
    logic [15:0]    rx_htype;
    logic [15:0]    rx_ptype;
    arp_pkg::oper_t rx_oper;
    arp_pkg::mac_t  rx_sha;
    arp_pkg::ip_t   rx_spa;
    arp_pkg::ip_t   rx_tpa;
    logic           rx_ready;
    logic           tx_ready;
    logic           tx_valid;
    arp_pkg::mac_t  tx_dest_mac;
    arp_pkg::oper_t tx_oper;
    arp_pkg::mac_t  tx_tha;
    arp_pkg::ip_t   tx_tpa;
    logic           req_valid;
    arp_pkg::ip_t   req_ip;
    logic           rsp_ready;
    logic           req_ready;
    logic           rsp_valid;
    logic           rsp_err;
    arp_pkg::mac_t  rsp_mac;

    // Frames are {dest, oper, tha, tpa} and responses {err, mac}
    logic [143:0]   tx_q [$];
    logic [143:0]   exp_q [$];
    logic [48:0]    rsp_q [$];
    int             tx_rd;
    int             rsp_rd;
    int             errors;
    int             checks;
    logic [31:0]    stim_seed;

    `include "tb_arp_model.svh"

    arp_top #(
        .CACHE_ADDRW (CACHE_ADDRW),
        .REQ_RET_CNT (REQ_RET_CNT),
        .REQ_RET_INT (REQ_RET_INT),
        .REQ_TIMEOUT (REQ_TIMEOUT)
    ) u_arp_top (.*);

    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic arp_pkg::mac_t random_mac();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random(stim_seed);
        lo = next_random(stim_seed);
        return {hi[31:16], lo};
    endfunction

    // Host part stays clear of the network and broadcast addresses
    function automatic arp_pkg::ip_t random_host();
        logic [31:0] r;
        logic [7:0]  host;
        r    = next_random(stim_seed);
        host = r[23:16] % 8'd253 + 8'd2;
        return (local_ip & subnet_mask) | {24'd0, host};
    endfunction

    function automatic arp_pkg::ip_t unknown_host();
        arp_pkg::ip_t  ip;
        arp_pkg::mac_t mac;
        ip = random_host();
        while (ip == local_ip || model_lookup(ip, mac)) begin
            ip = random_host();
        end
        return ip;
    endfunction

    task automatic compare_mac(input string what, input arp_pkg::mac_t got,
                               input arp_pkg::mac_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_ip(input string what, input arp_pkg::ip_t got, input arp_pkg::ip_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_oper(input string what, input arp_pkg::oper_t got,
                                input arp_pkg::oper_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_frame(input string what, input logic [143:0] exp);
        logic [143:0] got;
        got = tx_q[tx_rd];
        tx_rd++;
        compare_mac($sformatf("%s dest", what), got[143:96], exp[143:96]);
        compare_oper($sformatf("%s oper", what), got[95:80], exp[95:80]);
        compare_mac($sformatf("%s tha", what), got[79:32], exp[79:32]);
        compare_ip($sformatf("%s tpa", what), got[31:0], exp[31:0]);
    endtask

    task automatic check_tx_count(input int exp);
        checks++;
        if (tx_q.size() - tx_rd != exp) begin
            errors++;
            $display("error at %0t ns: %0d tx frames seen, expected %0d", $time,
                     tx_q.size() - tx_rd, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // The Ethernet source MAC is drawn apart from the ARP sender address
    task automatic send_rx(input logic [15:0] eth_type, input logic [15:0] htype,
                           input logic [15:0] ptype, input arp_pkg::oper_t oper,
                           input arp_pkg::mac_t sha, input arp_pkg::ip_t spa,
                           input arp_pkg::ip_t tpa);
        arp_pkg::mac_t src_mac;
        src_mac = random_mac();
        @(posedge clk);
        #DRIVE_DLY;
        rx_valid    = 1'b1;
        rx_eth_type = eth_type;
        rx_src_mac  = src_mac;
        rx_htype    = htype;
        rx_ptype    = ptype;
        rx_oper     = oper;
        rx_sha      = sha;
        rx_spa      = spa;
        rx_tpa      = tpa;
        @(negedge clk);
        while (!rx_ready) @(negedge clk);
        @(posedge clk);
        #DRIVE_DLY;
        rx_valid = 1'b0;
        model_rx(eth_type, htype, ptype, oper, src_mac, sha, spa, tpa);
    endtask

    task automatic issue_request(input arp_pkg::ip_t ip);
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b1;
        req_ip    = ip;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #DRIVE_DLY;
        req_valid = 1'b0;
    endtask

    task automatic take_response(output logic err, output arp_pkg::mac_t mac);
        while (rsp_q.size() == rsp_rd) @(negedge clk);
        {err, mac} = rsp_q[rsp_rd];
        rsp_rd++;
    endtask

    // One client request checked end to end with any request frames
    task automatic check_resolve(input arp_pkg::ip_t ip);
        arp_pkg::ip_t  target;
        logic          exp_err;
        arp_pkg::mac_t exp_mac;
        logic          got_err;
        arp_pkg::mac_t got_mac;
        logic          miss;
        miss = model_resolve(ip, target, exp_err, exp_mac);
        issue_request(ip);
        take_response(got_err, got_mac);
        compare_flag($sformatf("rsp_err for %h", ip), got_err, exp_err);
        compare_mac($sformatf("rsp_mac for %h", ip), got_mac, exp_mac);
        wait_cycles(4);
        check_tx_count(miss ? REQ_RET_CNT : 0);
        while (tx_q.size() > tx_rd) begin
            check_frame("request frame", model_request_frame(target));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Random back-pressure with ready low about a quarter of the cycles
    initial begin
        logic [31:0] bp_seed;
        logic [31:0] r;
        bp_seed   = SEED;
        tx_ready  = 1'b0;
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            r         = next_random(bp_seed);
            tx_ready  = r[17:16] != 2'b00;
            rsp_ready = r[21:20] != 2'b00;
        end
    end

    // Handshakes are sampled mid-cycle ahead of the edge that completes them
    always @(negedge clk) begin
        if (!reset && tx_valid && tx_ready) begin
            tx_q.push_back({tx_dest_mac, tx_oper, tx_tha, tx_tpa});
        end
        if (!reset && rsp_valid && rsp_ready) begin
            rsp_q.push_back({rsp_err, rsp_mac});
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        arp_pkg::ip_t  ip;
        arp_pkg::mac_t mac;
        logic          got_err;
        arp_pkg::mac_t got_mac;
        logic [31:0]   r;
        int            prefix;
        stim_seed   = SEED;
        reset       = 1'b1;
        local_mac   = 48'h02_00_00_00_00_05;
        local_ip    = 32'h0a00_0005;
        gateway_ip  = 32'h0a00_0001;
        subnet_mask = 32'hffff_ff00;
        clear_cache = 1'b0;
        rx_valid    = 1'b0;
        rx_eth_type = '0;
        rx_src_mac  = '0;
        rx_htype    = '0;
        rx_ptype    = '0;
        rx_oper     = '0;
        rx_sha      = '0;
        rx_spa      = '0;
        rx_tpa      = '0;
        req_valid   = 1'b0;
        req_ip      = '0;
        model_clear();
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        // Limited and subnet-directed broadcasts under random prefixes
        check_resolve(arp_pkg::IP_BROADCAST);
        for (int i = 0; i < 6; i++) begin
            r           = next_random(stim_seed);
            prefix      = 16 + int'(r[19:16]) % 14;
            subnet_mask = ~(32'hffff_ffff >> prefix);
            check_resolve((local_ip & subnet_mask) | ~subnet_mask);
        end
        subnet_mask = 32'hffff_ff00;

        // Replies to requests for our address and then frames that get none
        for (int i = 0; i < 8; i++) begin
            send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                    arp_pkg::OPER_REQUEST, random_mac(), random_host(), local_ip);
        end
        while (tx_q.size() - tx_rd < exp_q.size()) @(negedge clk);
        while (exp_q.size() > 0) begin
            check_frame("reply frame", exp_q.pop_front());
        end
        send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                arp_pkg::OPER_REQUEST, random_mac(), random_host(), local_ip + 32'd1);
        send_rx(16'h0800, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                arp_pkg::OPER_REQUEST, random_mac(), random_host(), local_ip);
        send_rx(arp_pkg::ETH_TYPE_ARP, 16'h0006, arp_pkg::PTYPE_IPV4,
                arp_pkg::OPER_REQUEST, random_mac(), random_host(), local_ip);
        wait_cycles(10);
        check_tx_count(0);

        // Learning and hits on-subnet and through the gateway
        for (int i = 0; i < 12; i++) begin
            send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                    arp_pkg::OPER_REPLY, random_mac(), random_host(), local_ip);
        end
        send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                arp_pkg::OPER_REPLY, random_mac(), gateway_ip, local_ip);
        for (int i = 0; i < MODEL_DEPTH; i++) begin
            if (model_valid[i] && model_ip[i] != gateway_ip) begin
                check_resolve(model_ip[i]);
            end
        end
        r = next_random(stim_seed);
        check_resolve({8'd8, r[23:0]});
        ip = unknown_host();
        send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, 16'h86dd,
                arp_pkg::OPER_REPLY, random_mac(), ip, local_ip);
        check_resolve(ip);

        // Unknown host runs into the final timeout
        check_resolve(unknown_host());

        // Answer arrives after the first request frame
        ip  = unknown_host();
        mac = random_mac();
        issue_request(ip);
        while (tx_q.size() == tx_rd) @(negedge clk);
        send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                arp_pkg::OPER_REPLY, mac, ip, local_ip);
        take_response(got_err, got_mac);
        compare_flag("late answer rsp_err", got_err, 1'b0);
        compare_mac("late answer rsp_mac", got_mac, mac);
        wait_cycles(4);
        if (tx_q.size() - tx_rd > REQ_RET_CNT) begin
            errors++;
            $display("more than %0d request frames were sent for a late answer", REQ_RET_CNT);
        end
        while (tx_q.size() > tx_rd) begin
            check_frame("late answer request frame", model_request_frame(ip));
        end

        // A learned host misses after the cache is cleared
        ip = unknown_host();
        send_rx(arp_pkg::ETH_TYPE_ARP, arp_pkg::HTYPE_ETHERNET, arp_pkg::PTYPE_IPV4,
                arp_pkg::OPER_REPLY, random_mac(), ip, local_ip);
        check_resolve(ip);
        @(posedge clk);
        #DRIVE_DLY;
        clear_cache = 1'b1;
        model_clear();
        @(posedge clk);
        #DRIVE_DLY;
        clear_cache = 1'b0;
        check_resolve(ip);

        $display("tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog/arp_top.sv
`timescale 1ns/10ps

module arp_top #(
    parameter int CACHE_ADDRW = arp_pkg::DEFAULT_CACHE_ADDRW,
    parameter int REQ_RET_CNT = 4,
    parameter int REQ_RET_INT = 250_000_000,
    parameter int REQ_TIMEOUT = 1_250_000_000
) (
    input  logic            clk,
    input  logic            reset,

    // Network configuration
    // Sender MAC and IP of outgoing frames are filled in by the framing layer
    input  arp_pkg::mac_t   local_mac,
    input  arp_pkg::ip_t    local_ip,
    input  arp_pkg::ip_t    gateway_ip,
    input  arp_pkg::ip_t    subnet_mask,
    input  logic            clear_cache,

    // Parsed receive frame
    input  logic            rx_valid,
    input  logic [15:0]     rx_eth_type,
    input  arp_pkg::mac_t   rx_src_mac,
    input  logic [15:0]     rx_htype,
    input  logic [15:0]     rx_ptype,
    input  arp_pkg::oper_t  rx_oper,
    input  arp_pkg::mac_t   rx_sha,
    input  arp_pkg::ip_t    rx_spa,
    input  arp_pkg::ip_t    rx_tpa,
    output logic            rx_ready,

    // Transmit frame
    input  logic            tx_ready,
    output logic            tx_valid,
    output arp_pkg::mac_t   tx_dest_mac,
    output arp_pkg::oper_t  tx_oper,
    output arp_pkg::mac_t   tx_tha,
    output arp_pkg::ip_t    tx_tpa,

    // Client resolution
    input  logic            req_valid,
    input  arp_pkg::ip_t    req_ip,
    input  logic            rsp_ready,
    output logic            req_ready,
    output logic            rsp_valid,
    output logic            rsp_err,
    output arp_pkg::mac_t   rsp_mac
);

    arp_tx_frame_if reply_if ();
    arp_tx_frame_if request_if ();
    arp_cache_if    cache_if ();

    logic           write_valid;
    arp_pkg::ip_t   write_ip;
    arp_pkg::mac_t  write_mac;

    arp_rx_filter u_rx_filter (
        .clk         (clk),
        .reset       (reset),
        .local_ip    (local_ip),
        .rx_valid    (rx_valid),
        .rx_eth_type (rx_eth_type),
        .rx_src_mac  (rx_src_mac),
        .rx_htype    (rx_htype),
        .rx_ptype    (rx_ptype),
        .rx_oper     (rx_oper),
        .rx_sha      (rx_sha),
        .rx_spa      (rx_spa),
        .rx_tpa      (rx_tpa),
        .rx_ready    (rx_ready),
        .write_valid (write_valid),
        .write_ip    (write_ip),
        .write_mac   (write_mac),
        .reply       (reply_if.source)
    );

    arp_cache #(
        .CACHE_ADDRW (CACHE_ADDRW)
    ) u_cache (
        .clk         (clk),
        .reset       (reset),
        .clear_cache (clear_cache),
        .write_valid (write_valid),
        .write_ip    (write_ip),
        .write_mac   (write_mac),
        .query       (cache_if.cache)
    );

    arp_resolver #(
        .REQ_RET_CNT (REQ_RET_CNT),
        .REQ_RET_INT (REQ_RET_INT),
        .REQ_TIMEOUT (REQ_TIMEOUT)
    ) u_resolver (
        .clk         (clk),
        .reset       (reset),
        .gateway_ip  (gateway_ip),
        .subnet_mask (subnet_mask),
        .req_valid   (req_valid),
        .req_ip      (req_ip),
        .rsp_ready   (rsp_ready),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_err     (rsp_err),
        .rsp_mac     (rsp_mac),
        .query       (cache_if.requester),
        .request     (request_if.source)
    );

    arp_tx_arbiter u_tx_arbiter (
        .clk         (clk),
        .reset       (reset),
        .tx_ready    (tx_ready),
        .tx_valid    (tx_valid),
        .tx_dest_mac (tx_dest_mac),
        .tx_oper     (tx_oper),
        .tx_tha      (tx_tha),
        .tx_tpa      (tx_tpa),
        .reply       (reply_if.sink),
        .request     (request_if.sink)
    );

endmodule

//--- verilog/arp_tx_arbiter.sv
`timescale 1ns/10ps

module arp_tx_arbiter (
    input  logic            clk,
    input  logic            reset,
    input  logic            tx_ready,
    output logic            tx_valid,
    output arp_pkg::mac_t   tx_dest_mac,
    output arp_pkg::oper_t  tx_oper,
    output arp_pkg::mac_t   tx_tha,
    output arp_pkg::ip_t    tx_tpa,
    arp_tx_frame_if.sink    reply,
    arp_tx_frame_if.sink    request
);

    logic load;

    // Output register is free or drains this cycle
    assign load = !tx_valid || tx_ready;

    // Replies take priority over our own requests
    assign reply.ready   = load;
    assign request.ready = load && !reply.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_valid <= 1'b0;
        end else if (load) begin
            tx_valid <= reply.valid || request.valid;
        end
        if (load && reply.valid) begin
            tx_dest_mac <= reply.dest_mac;
            tx_oper     <= reply.oper;
            tx_tha      <= reply.tha;
            tx_tpa      <= reply.tpa;
        end else if (load && request.valid) begin
            tx_dest_mac <= request.dest_mac;
            tx_oper     <= request.oper;
            tx_tha      <= request.tha;
            tx_tpa      <= request.tpa;
        end
    end

    tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_dest_mac) && $stable(tx_oper) &&
        $stable(tx_tha) && $stable(tx_tpa));

endmodule

//--- verilog/arp_resolver.sv
`timescale 1ns/10ps

module arp_resolver #(
    parameter int REQ_RET_CNT = 4,
    parameter int REQ_RET_INT = 250_000_000,
    parameter int REQ_TIMEOUT = 1_250_000_000
) (
    input  logic            clk,
    input  logic            reset,
    input  arp_pkg::ip_t    gateway_ip,
    input  arp_pkg::ip_t    subnet_mask,
    input  logic            req_valid,
    input  arp_pkg::ip_t    req_ip,
    input  logic            rsp_ready,
    output logic            req_ready,
    output logic            rsp_valid,
    output logic            rsp_err,
    output arp_pkg::mac_t   rsp_mac,
    arp_cache_if.requester  query,
    arp_tx_frame_if.source  request
);

    localparam int TIMER_MAX  = (REQ_RET_INT > REQ_TIMEOUT) ? REQ_RET_INT : REQ_TIMEOUT;
    localparam int TIMER_W    = $clog2(TIMER_MAX + 1);
    localparam int RETRY_W    = $clog2(REQ_RET_CNT + 1);
    // A single attempt goes straight to the final timeout
    localparam int FIRST_WAIT = (REQ_RET_CNT > 1) ? REQ_RET_INT : REQ_TIMEOUT;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t              state;
    state_t              state_n;
    arp_pkg::ip_t        target_ip;
    arp_pkg::ip_t        target_ip_n;
    logic [RETRY_W-1:0]  retry_cnt;
    logic [RETRY_W-1:0]  retry_cnt_n;
    logic [TIMER_W-1:0]  timer;
    logic [TIMER_W-1:0]  timer_n;
    logic                frame_valid;
    logic                frame_valid_n;
    logic                rsp_err_n;
    arp_pkg::mac_t       rsp_mac_n;
    logic                on_subnet;
    logic                is_bcast;

    // Limited broadcast, or all host bits set inside our subnet
    assign on_subnet = ((req_ip ^ gateway_ip) & subnet_mask) == '0;
    assign is_bcast  = (req_ip == arp_pkg::IP_BROADCAST) ||
                       (on_subnet && ((req_ip | subnet_mask) == arp_pkg::IP_BROADCAST));

    assign rsp_valid         = (state == ST_RESP);
    assign query.query_valid = (state == ST_LOOKUP) || (state == ST_WAIT);
    assign query.query_ip    = target_ip;

    // Broadcast request frame for the current target
    assign request.valid    = frame_valid;
    assign request.dest_mac = arp_pkg::MAC_BROADCAST;
    assign request.oper     = arp_pkg::OPER_REQUEST;
    assign request.tha      = arp_pkg::MAC_ZERO;
    assign request.tpa      = target_ip;

    always_comb begin
        state_n       = state;
        target_ip_n   = target_ip;
        retry_cnt_n   = retry_cnt;
        timer_n       = timer;
        frame_valid_n = frame_valid && !request.ready;
        rsp_err_n     = rsp_err;
        rsp_mac_n     = rsp_mac;
        case (state)
            ST_IDLE: begin
                if (req_valid && req_ready) begin
                    if (is_bcast) begin
                        state_n   = ST_RESP;
                        rsp_err_n = 1'b0;
                        rsp_mac_n = arp_pkg::MAC_BROADCAST;
                    end else begin
                        // Off-subnet hosts resolve through the gateway
                        state_n     = ST_LOOKUP;
                        target_ip_n = on_subnet ? req_ip : gateway_ip;
                    end
                end
            end
            ST_LOOKUP: begin
                if (query.rsp_valid && query.rsp_hit) begin
                    state_n   = ST_RESP;
                    rsp_err_n = 1'b0;
                    rsp_mac_n = query.rsp_mac;
                end else if (query.rsp_valid) begin
                    state_n       = ST_WAIT;
                    frame_valid_n = 1'b1;
                    retry_cnt_n   = RETRY_W'(REQ_RET_CNT - 1);
                    timer_n       = TIMER_W'(FIRST_WAIT);
                end
            end
            ST_WAIT: begin
                if (query.rsp_valid && query.rsp_hit) begin
                    state_n   = ST_RESP;
                    rsp_err_n = 1'b0;
                    rsp_mac_n = query.rsp_mac;
                end else if (timer == '0) begin
                    if (retry_cnt != '0) begin
                        frame_valid_n = 1'b1;
                        retry_cnt_n   = retry_cnt - 1'b1;
                        timer_n       = (retry_cnt > 1) ? TIMER_W'(REQ_RET_INT)
                                                        : TIMER_W'(REQ_TIMEOUT);
                    end else begin
                        state_n   = ST_RESP;
                        rsp_err_n = 1'b1;
                        rsp_mac_n = arp_pkg::MAC_ZERO;
                    end
                end else begin
                    timer_n = timer - 1'b1;
                end
            end
            ST_RESP: begin
                if (rsp_ready) begin
                    state_n = ST_IDLE;
                end
            end
            default: begin
                state_n = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            frame_valid <= 1'b0;
            req_ready   <= 1'b0;
            retry_cnt   <= '0;
            timer       <= '0;
        end else begin
            state       <= state_n;
            frame_valid <= frame_valid_n;
            // New target only once the last request frame has left
            req_ready   <= (state_n == ST_IDLE) && !frame_valid_n;
            retry_cnt   <= retry_cnt_n;
            timer       <= timer_n;
        end
        target_ip <= target_ip_n;
        rsp_err   <= rsp_err_n;
        rsp_mac   <= rsp_mac_n;
    end

    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_err) && $stable(rsp_mac));

    ready_excl: assert property (@(posedge clk) disable iff (reset)
        !(req_ready && rsp_valid));

endmodule

//--- verilog/arp_rx_filter.sv
`timescale 1ns/10ps

module arp_rx_filter (
    input  logic            clk,
    input  logic            reset,
    input  arp_pkg::ip_t    local_ip,
    input  logic            rx_valid,
    input  logic [15:0]     rx_eth_type,
    input  arp_pkg::mac_t   rx_src_mac,
    input  logic [15:0]     rx_htype,
    input  logic [15:0]     rx_ptype,
    input  arp_pkg::oper_t  rx_oper,
    input  arp_pkg::mac_t   rx_sha,
    input  arp_pkg::ip_t    rx_spa,
    input  arp_pkg::ip_t    rx_tpa,
    output logic            rx_ready,
    output logic            write_valid,
    output arp_pkg::ip_t    write_ip,
    output arp_pkg::mac_t   write_mac,
    arp_tx_frame_if.source  reply
);

    logic accept;
    logic frame_ok;
    logic want_reply;
    logic reply_valid_n;

    assign accept   = rx_valid && rx_ready;
    assign frame_ok = (rx_eth_type == arp_pkg::ETH_TYPE_ARP) &&
                      (rx_htype == arp_pkg::HTYPE_ETHERNET) &&
                      (rx_ptype == arp_pkg::PTYPE_IPV4);

    // Only requests for our own address are answered
    assign want_reply = frame_ok && (rx_oper == arp_pkg::OPER_REQUEST) && (rx_tpa == local_ip);

    assign reply_valid_n = (reply.valid && !reply.ready) || (accept && want_reply);
    assign reply.oper    = arp_pkg::OPER_REPLY;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_ready    <= 1'b0;
            write_valid <= 1'b0;
            reply.valid <= 1'b0;
        end else begin
            // Stall the input while a reply waits for the arbiter
            rx_ready    <= !reply_valid_n;
            write_valid <= accept && frame_ok;
            reply.valid <= reply_valid_n;
        end
        if (accept) begin
            write_ip  <= rx_spa;
            write_mac <= rx_sha;
        end
        if (accept && want_reply) begin
            reply.dest_mac <= rx_src_mac;
            reply.tha      <= rx_sha;
            reply.tpa      <= rx_spa;
        end
    end

    reply_hold: assert property (@(posedge clk) disable iff (reset)
        reply.valid && !reply.ready |=> reply.valid && $stable(reply.dest_mac) &&
        $stable(reply.oper) && $stable(reply.tha) && $stable(reply.tpa));

endmodule

//--- verilog/arp_cache.sv
`timescale 1ns/10ps

module arp_cache #(
    parameter int CACHE_ADDRW = arp_pkg::DEFAULT_CACHE_ADDRW
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           clear_cache,
    input  logic           write_valid,
    input  arp_pkg::ip_t   write_ip,
    input  arp_pkg::mac_t  write_mac,
    arp_cache_if.cache     query
);

    localparam int DEPTH = 1 << CACHE_ADDRW;

    logic [DEPTH-1:0]        valid_bits;
    arp_pkg::ip_t            tag_mem [DEPTH];
    arp_pkg::mac_t           mac_mem [DEPTH];
    logic [CACHE_ADDRW-1:0]  wr_idx;
    logic [CACHE_ADDRW-1:0]  rd_idx;

    // Direct mapped on the low bits of the IP
    assign wr_idx = write_ip[CACHE_ADDRW-1:0];
    assign rd_idx = query.query_ip[CACHE_ADDRW-1:0];

    // Clear wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (reset || clear_cache) begin
            valid_bits <= '0;
        end else if (write_valid) begin
            valid_bits[wr_idx] <= 1'b1;
        end
    end

    // Full IP kept as tag so aliased entries never hit
    always_ff @(posedge clk) begin
        if (write_valid) begin
            tag_mem[wr_idx] <= write_ip;
            mac_mem[wr_idx] <= write_mac;
        end
    end

    // Reads see the contents from before a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            query.rsp_valid <= 1'b0;
        end else begin
            query.rsp_valid <= query.query_valid;
        end
        query.rsp_hit <= valid_bits[rd_idx] && (tag_mem[rd_idx] == query.query_ip);
        query.rsp_mac <= mac_mem[rd_idx];
    end

endmodule

//--- verilog/arp_cache_if.sv
`timescale 1ns/10ps

// Cache lookup, response follows the query by exactly one cycle
interface arp_cache_if;

    logic            query_valid;
    arp_pkg::ip_t    query_ip;
    logic            rsp_valid;
    logic            rsp_hit;
    arp_pkg::mac_t   rsp_mac;

    modport requester (output query_valid, query_ip, input rsp_valid, rsp_hit, rsp_mac);
    modport cache     (input query_valid, query_ip, output rsp_valid, rsp_hit, rsp_mac);

endinterface

//--- verilog/arp_tx_frame_if.sv
`timescale 1ns/10ps

// One outgoing ARP frame, header constants are added downstream
interface arp_tx_frame_if;

    logic            valid;
    logic            ready;
    arp_pkg::mac_t   dest_mac;
    arp_pkg::oper_t  oper;
    arp_pkg::mac_t   tha;
    arp_pkg::ip_t    tpa;

    modport source (output valid, dest_mac, oper, tha, tpa, input ready);
    modport sink   (input valid, dest_mac, oper, tha, tpa, output ready);

endinterface

//--- verilog/arp_pkg.sv
package arp_pkg;

    // Address and header field types
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] oper_t;

    // Header values checked on receive
    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
    localparam logic [15:0] HTYPE_ETHERNET = 16'h0001;
    localparam logic [15:0] PTYPE_IPV4     = 16'h0800;

    // ARP operations
    localparam oper_t OPER_REQUEST = 16'd1;
    localparam oper_t OPER_REPLY   = 16'd2;

    // Well known addresses
    localparam mac_t MAC_BROADCAST = 48'hffff_ffff_ffff;
    localparam mac_t MAC_ZERO      = 48'h0000_0000_0000;
    localparam ip_t  IP_BROADCAST  = 32'hffff_ffff;

    // Log2 of the number of cache entries
    localparam integer DEFAULT_CACHE_ADDRW = 8;

endpackage
